// ==== rtl/sram_pkg.sv ====
//----------------------------------------------------------
// sram geometry
// word depth, index width and the two views of a data word
//----------------------------------------------------------
`default_nettype none

package sram_pkg;

  localparam int DEPTH   = 64;
  localparam int INDEX_W = 6;
  localparam int LANES   = 4;

  // one memory word, seen whole or as byte lanes
  // lane 0 is the least significant byte
  typedef union packed {
    logic [31:0]          word;
    logic [LANES-1:0][7:0] lanes;
  } word_u;

endpackage

`default_nettype wire

// ==== rtl/ahb_pkg.sv ====
//----------------------------------------------------------
// ahb bus definitions
// transfer, size and response encodings, bus widths and
// the control word carried from address to data phase
//----------------------------------------------------------
`default_nettype none

package ahb_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  //----------------------------------------------------------
  // protocol encodings
  //----------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // encodings above word stay unnamed, they are illegal here
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  //----------------------------------------------------------
  // data-phase control
  //----------------------------------------------------------
  typedef struct packed {
    logic                          xfer;
    logic                          err;
    logic                          write;
    logic [sram_pkg::INDEX_W-1:0]  index;
    logic [sram_pkg::LANES-1:0]    byte_en;
  } dphase_t;

endpackage

`default_nettype wire

// ==== rtl/ahb_addr_decode.sv ====
//----------------------------------------------------------
// ahb address-phase decoder
// samples an accepted address phase, checks range,
// alignment and size, and hands the result on as the
// control word for the data phase
//----------------------------------------------------------
`default_nettype none

module ahb_addr_decode (
  input  wire logic              HCLK,
  input  wire logic              HRESETn,
  input  wire logic              hsel,
  input  wire logic [ahb_pkg::ADDR_W-1:0] haddr,
  input  wire ahb_pkg::htrans_t  htrans,
  input  wire logic              hwrite,
  input  wire ahb_pkg::hsize_t   hsize,
  input  wire logic              hready,
  output ahb_pkg::dphase_t       dphase
);

  logic                          is_xfer;
  logic                          out_of_range;
  logic                          misaligned;
  logic                          oversize;
  logic [sram_pkg::LANES-1:0]    lanes;
  ahb_pkg::dphase_t              dphase_d;

  //----------------------------------------------------------
  // legality and lane decode
  //----------------------------------------------------------
  always_comb begin
    is_xfer = hsel && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);

    // word index plus every address bit above it
    out_of_range = haddr[ahb_pkg::ADDR_W-1:2] >= (ahb_pkg::ADDR_W-2)'(sram_pkg::DEPTH);

    misaligned = 1'b0;
    lanes      = '0;
    case (hsize)
      ahb_pkg::BYTE: begin
        lanes = sram_pkg::LANES'(1) << haddr[1:0];
      end
      ahb_pkg::HALF: begin
        misaligned = haddr[0];
        lanes      = sram_pkg::LANES'(3) << {haddr[1], 1'b0};
      end
      ahb_pkg::WORD: begin
        misaligned = |haddr[1:0];
        lanes      = '1;
      end
      default: begin
        lanes = '0;
      end
    endcase

    oversize = hsize > ahb_pkg::WORD;

    // empty unless a transfer is seen
    dphase_d = '0;
    if (is_xfer) begin
      if (out_of_range || misaligned || oversize) begin
        dphase_d.err = 1'b1;
      end else begin
        dphase_d.xfer    = 1'b1;
        dphase_d.write   = hwrite;
        dphase_d.index   = haddr[2 +: sram_pkg::INDEX_W];
        dphase_d.byte_en = lanes;
      end
    end
  end

  //----------------------------------------------------------
  // address to data phase register
  //----------------------------------------------------------
  // holds while a wait state stretches the data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dphase <= '0;
    end else if (hready) begin
      dphase <= dphase_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sram_array.sv ====
//----------------------------------------------------------
// sram storage array
// register-file words with byte-lane writes at the end of
// the data phase and an asynchronous word read
//----------------------------------------------------------
`default_nettype none

module sram_array (
  input  wire logic              HCLK,
  input  wire logic              HRESETn,
  input  wire ahb_pkg::dphase_t  dphase,
  input  wire sram_pkg::word_u   hwdata,
  output sram_pkg::word_u        rdata
);

  sram_pkg::word_u mem [sram_pkg::DEPTH];

  logic wr_en;

  // only legal writes reach the array
  assign wr_en = dphase.xfer && dphase.write;

  //----------------------------------------------------------
  // write port
  //----------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int i = 0; i < sram_pkg::DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      // merge enabled lanes, the rest keep their old bytes
      for (int l = 0; l < sram_pkg::LANES; l++) begin
        if (dphase.byte_en[l]) begin
          mem[dphase.index].lanes[l] <= hwdata.lanes[l];
        end
      end
    end
  end

  //----------------------------------------------------------
  // read port
  //----------------------------------------------------------
  // indexed word is always visible, response stage qualifies it
  assign rdata = mem[dphase.index];

endmodule

`default_nettype wire

// ==== rtl/ahb_resp_gen.sv ====
//----------------------------------------------------------
// ahb response stage
// drives hreadyout, hresp and hrdata for the data phase,
// stretching an illegal transfer into the two-cycle error
//----------------------------------------------------------
`default_nettype none

module ahb_resp_gen (
  input  wire logic              HCLK,
  input  wire logic              HRESETn,
  input  wire ahb_pkg::dphase_t  dphase,
  input  wire sram_pkg::word_u   rdata,
  output logic [ahb_pkg::DATA_W-1:0] hrdata,
  output logic                   hreadyout,
  output ahb_pkg::hresp_t        hresp
);

  // high in the second cycle of an error response
  logic err_second;
  logic rd_hit;

  //----------------------------------------------------------
  // error sequencing
  //----------------------------------------------------------
  // first error cycle sets the flag, the next one clears it
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      err_second <= 1'b0;
    end else begin
      err_second <= dphase.err && !err_second;
    end
  end

  //----------------------------------------------------------
  // response outputs
  //----------------------------------------------------------
  assign rd_hit = dphase.xfer && !dphase.write;

  always_comb begin
    // wait state only in the first error cycle
    hreadyout = !(dphase.err && !err_second);

    if (dphase.err) begin
      hresp = ahb_pkg::ERROR;
    end else begin
      hresp = ahb_pkg::OKAY;
    end

    // zero outside a legal read
    if (rd_hit) begin
      hrdata = rdata.word;
    end else begin
      hrdata = '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ahb_sram.sv ====
//----------------------------------------------------------
// ahb-lite sram subordinate
// zero-wait single transfers into a 64-word memory,
// with the two-cycle error for illegal transfers
//----------------------------------------------------------
`default_nettype none

module ahb_sram (
  input  wire logic              HCLK,
  input  wire logic              HRESETn,
  input  wire logic              hsel,
  input  wire logic [ahb_pkg::ADDR_W-1:0] haddr,
  input  wire ahb_pkg::htrans_t  htrans,
  input  wire logic              hwrite,
  input  wire ahb_pkg::hsize_t   hsize,
  input  wire logic [ahb_pkg::DATA_W-1:0] hwdata,
  input  wire logic              hready,
  output logic [ahb_pkg::DATA_W-1:0] hrdata,
  output logic                   hreadyout,
  output ahb_pkg::hresp_t        hresp
);

  ahb_pkg::dphase_t  dphase;
  sram_pkg::word_u   rdata;

  // address phase in, control word out
  ahb_addr_decode u_decode (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hsel    (hsel),
    .haddr   (haddr),
    .htrans  (htrans),
    .hwrite  (hwrite),
    .hsize   (hsize),
    .hready  (hready),
    .dphase  (dphase)
  );

  sram_array u_array (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .dphase  (dphase),
    .hwdata  (hwdata),
    .rdata   (rdata)
  );

  ahb_resp_gen u_resp (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .dphase    (dphase),
    .rdata     (rdata),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp)
  );

endmodule

`default_nettype wire

// ==== tests/ahb_sram_tb.sv ====
//----------------------------------------------------------
// ahb sram testbench
// single-transfer ahb manager with lfsr stimulus, a word
// model of the memory, response checks and a watchdog
//----------------------------------------------------------
`default_nettype none

module ahb_sram_tb;

  localparam int NUM_XFERS    = 400;
  localparam int DIRECT_READS = 16;
  localparam int TIMEOUT      = (NUM_XFERS * 3 + 20) * 4;

  logic              HCLK;
  logic              HRESETn;
  logic              hsel;
  logic [31:0]       haddr;
  ahb_pkg::htrans_t  htrans;
  logic              hwrite;
  ahb_pkg::hsize_t   hsize;
  logic [31:0]       hwdata;
  logic [31:0]       hrdata;
  logic              hreadyout;
  ahb_pkg::hresp_t   hresp;

  logic [31:0] model_mem [64];
  logic [31:0] lfsr;
  int          errors;
  int          checks;

  // next address phase
  logic        a_sel;
  logic [1:0]  a_trans;
  logic        a_write;
  logic [2:0]  a_size;
  logic [31:0] a_addr;
  logic [31:0] a_wdata;
  logic        follow;
  logic [5:0]  follow_index;

  // data phase under way, kind 0 none, 1 legal, 2 error
  int          dp_kind;
  int          dp_num;
  string       dp_label;
  logic        dp_write;
  logic [5:0]  dp_index;
  logic [3:0]  dp_lanes;
  logic [31:0] dp_wdata;

  // single subordinate, so hready loops back from hreadyout
  ahb_sram dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hwdata    (hwdata),
    .hready    (hreadyout),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp)
  );

  initial HCLK = 1'b0;
  always #2 HCLK = ~HCLK;

  //----------------------------------------------------------
  // stimulus helpers
  //----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit, msb first
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [3:0] lanes_for(input logic [2:0] size, input logic [1:0] off);
    case (size)
      3'd0:    return 4'b0001 << off;
      3'd1:    return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  en);
    logic [31:0] r;
    r = old_word;
    for (int l = 0; l < 4; l++) begin
      if (en[l]) begin
        r[8*l +: 8] = new_word[8*l +: 8];
      end
    end
    return r;
  endfunction

  // range, size and alignment rules
  function automatic logic is_illegal(input logic [2:0] size, input logic [31:0] addr);
    return (addr[31:8] != 24'h0) || (size > 3'd2) ||
           (size == 3'd1 && addr[0]) || (size == 3'd2 && addr[1:0] != 2'b00);
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic pick_transfer(input int n);
    logic [3:0] kind;
    logic [3:0] where;
    logic [1:0] off;
    a_sel   = 1'b1;
    a_trans = 2'b10;
    a_write = 1'b0;
    a_size  = 3'd2;
    a_wdata = take_bits(32);
    if (n < DIRECT_READS) begin
      a_addr = {24'h0, 6'(take_bits(6)), 2'b00};
    end else if (follow) begin
      // word read back of the word just touched
      a_addr = {24'h0, follow_index, 2'b00};
      follow = 1'b0;
    end else begin
      kind    = 4'(take_bits(4));
      a_write = 1'(take_bits(1));
      case (kind)
        4'd0:    a_trans = 2'b00;
        4'd1:    a_trans = 2'b01;
        4'd2:    a_sel   = 1'b0;
        default: a_trans = {1'b1, 1'(take_bits(1))};
      endcase
      if (3'(take_bits(3)) == 3'd0) begin
        a_size = 3'(take_bits(3));
      end else begin
        a_size = 3'(take_bits(2));
        if (a_size == 3'd3) begin
          a_size = 3'd2;
        end
      end
      where = 4'(take_bits(4));
      off   = 2'(take_bits(2));
      if (where == 4'd0) begin
        a_addr = take_bits(32) | 32'h100;
      end else begin
        // where 1 keeps a possibly misaligned offset
        if (where != 4'd1 && a_size == 3'd1) begin
          off[0] = 1'b0;
        end else if (where != 4'd1 && a_size == 3'd2) begin
          off = 2'b00;
        end
        a_addr = {24'h0, 6'(take_bits(6)), off};
      end
    end
  endtask

  //----------------------------------------------------------
  // data phase prediction and checks
  //----------------------------------------------------------
  task automatic load_data_phase(input int n);
    dp_num   = n;
    dp_kind  = 0;
    dp_label = "none";
    dp_write = a_write;
    dp_index = a_addr[7:2];
    dp_lanes = lanes_for(a_size, a_addr[1:0]);
    dp_wdata = a_wdata;
    if (a_sel && a_trans[1]) begin
      if (is_illegal(a_size, a_addr)) begin
        dp_kind  = 2;
        dp_label = "error";
      end else begin
        dp_kind  = 1;
        dp_label = a_write ? "write" : "read";
      end
    end
    if (dp_kind == 2 || (dp_kind == 1 && a_write && a_size != 3'd2)) begin
      follow       = 1'b1;
      follow_index = a_addr[7:2];
    end
  endtask

  task automatic check_data_phase();
    string       tag;
    logic [31:0] exp_data;
    tag      = $sformatf("xfer %0d %s", dp_num, dp_label);
    exp_data = 32'h0;
    if (dp_kind == 1 && !dp_write) begin
      exp_data = model_mem[dp_index];
    end
    if (dp_kind == 2) begin
      check({tag, " hreadyout 1st"}, 32'd0, 32'(hreadyout));
      check({tag, " hresp 1st"}, 32'd1, 32'(hresp));
      @(posedge HCLK);
      @(negedge HCLK);
      check({tag, " hreadyout 2nd"}, 32'd1, 32'(hreadyout));
      check({tag, " hresp 2nd"}, 32'd1, 32'(hresp));
    end else begin
      check({tag, " hreadyout"}, 32'd1, 32'(hreadyout));
      check({tag, " hresp"}, 32'd0, 32'(hresp));
    end
    check({tag, " hrdata"}, exp_data, hrdata);
  endtask

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------
  initial begin
    HRESETn = 1'b0;
    hsel    = 1'b0;
    haddr   = 32'h0;
    htrans  = ahb_pkg::IDLE;
    hwrite  = 1'b0;
    hsize   = ahb_pkg::WORD;
    hwdata  = 32'h0;
    lfsr    = 32'd7;
    errors  = 0;
    checks  = 0;
    follow  = 1'b0;
    a_sel   = 1'b0;
    a_trans = 2'b00;
    a_write = 1'b0;
    a_size  = 3'd2;
    a_addr  = 32'h0;
    a_wdata = 32'h0;
    load_data_phase(-1);
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = 32'h0;
    end

    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    @(negedge HCLK);
    check("reset hreadyout", 32'd1, 32'(hreadyout));
    check("reset hresp", 32'd0, 32'(hresp));
    check("reset hrdata", 32'd0, hrdata);
    @(posedge HCLK);
    #1;

    // address phase n overlaps the data phase of n-1
    for (int n = 0; n <= NUM_XFERS; n++) begin
      if (n < NUM_XFERS) begin
        pick_transfer(n);
      end else begin
        a_sel   = 1'b0;
        a_trans = 2'b00;
      end
      hsel   = a_sel;
      haddr  = a_addr;
      htrans = ahb_pkg::htrans_t'(a_trans);
      hwrite = a_write;
      hsize  = ahb_pkg::hsize_t'(a_size);
      hwdata = dp_wdata;
      @(negedge HCLK);
      check_data_phase();
      @(posedge HCLK);
      if (dp_kind == 1 && dp_write) begin
        model_mem[dp_index] = merge_lanes(model_mem[dp_index], dp_wdata, dp_lanes);
      end
      load_data_phase(n);
      #1;
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog: run did not finish within %0d time units", TIMEOUT);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ahb_sram.f ====
rtl/sram_pkg.sv
rtl/ahb_pkg.sv
rtl/ahb_addr_decode.sv
rtl/sram_array.sv
rtl/ahb_resp_gen.sv
rtl/ahb_sram.sv
tests/ahb_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the ahb sram testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module ahb_sram_tb \
  -f ahb_sram.f \
  -o Vahb_sram_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vahb_sram_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
echo "simulation reported failures"
exit 1
